/* dual_issue_defs.svh */
`ifndef DUAL_ISSUE_DEFS_SVH
`define DUAL_ISSUE_DEFS_SVH

// requesters feeding the arbiter
`define DI_N_REQ 6

// payload fields, tag on top
`define DI_TAG_W 4
`define DI_OP_W 2
`define DI_DATA_W 8

`define DI_PLD_W (`DI_TAG_W + `DI_OP_W + `DI_DATA_W)

// field positions inside a payload
`define DI_OP_LSB `DI_DATA_W
`define DI_TAG_LSB (`DI_OP_W + `DI_DATA_W)

`endif

/* dual_issue_pkg.sv */
`include "dual_issue_defs.svh"

package dual_issue_pkg;

    // requester id, travels with every operation
    typedef logic [`DI_TAG_W-1:0] tag_t;

    // 0 pass, 1 increment, 2 bit-reverse, 3 popcount
    typedef logic [`DI_OP_W-1:0] op_t;

    typedef logic [`DI_DATA_W-1:0] data_t;

    // {tag, op, data}
    typedef logic [`DI_PLD_W-1:0] pld_t;

    typedef logic [`DI_N_REQ-1:0] req_mask_t;

endpackage

/* cmn_lead_one.sv */
`timescale 1ns/10ps

module cmn_lead_one #(
    parameter ENTRY_NUM = 8
) (
    input  logic [ENTRY_NUM-1:0] v_entry_vld,
    output logic [ENTRY_NUM-1:0] v_free_idx_oh,
    output logic                 v_free_vld
);

    logic [ENTRY_NUM-1:0] lower_set; // bit i: some bit below i is set

    always_comb begin
        lower_set[0] = 1'b0;
        for (int i = 1; i < ENTRY_NUM; i++) begin
            lower_set[i] = lower_set[i-1] | v_entry_vld[i-1];
        end
    end

    // keep only the lowest set bit
    assign v_free_idx_oh = v_entry_vld & ~lower_set;
    assign v_free_vld    = |v_entry_vld;

endmodule

/* n_to_2_arb.sv */
`timescale 1ns/10ps

module n_to_2_arb #(
    parameter N         = 10,
    parameter PLD_WIDTH = 8
) (
    input  logic                 clk,   // unused, arbiter is combinational
    input  logic                 reset, // unused as well

    input  logic [N-1:0]         req_vld,
    output logic [N-1:0]         req_rdy,
    input  logic [PLD_WIDTH-1:0] req_pld [N-1:0],

    output logic [1:0]           grant_vld,
    input  logic [1:0]           grant_rdy,
    output logic [PLD_WIDTH-1:0] grant_pld [1:0]
);

    logic [N-1:0] lane_req [1:0]; // requests seen by each lane
    logic [N-1:0] grant_oh [1:0];

    // lane 1 picks from whatever lane 0 did not take
    assign lane_req[0] = req_vld;
    assign lane_req[1] = req_vld & ~grant_oh[0];

    for (genvar l = 0; l < 2; l++) begin : g_lane
        logic [PLD_WIDTH-1:0] sel_pld;

        // a lane that cannot take a grant is left out of the search,
        // so the other lane can still serve the lowest request
        cmn_lead_one #(
            .ENTRY_NUM(N)
        ) u_lead_one (
            .v_entry_vld  (lane_req[l] & {N{grant_rdy[l]}}),
            .v_free_idx_oh(grant_oh[l]),
            .v_free_vld   (grant_vld[l])
        );

        always_comb begin
            sel_pld = '0;
            for (int i = 0; i < N; i++) begin
                if (grant_oh[l][i]) begin
                    sel_pld = req_pld[i];
                end
            end
        end

        assign grant_pld[l] = sel_pld;
    end

    // both grants already gated by lane ready, so these are accepts
    assign req_rdy = grant_oh[0] | grant_oh[1];

endmodule

/* op_decode.sv */
`timescale 1ns/10ps
`include "dual_issue_defs.svh"

module op_decode (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 in_vld,
    output logic                 in_rdy,
    input  dual_issue_pkg::pld_t in_pld,

    output logic                 dec_vld,
    input  logic                 dec_rdy,
    output dual_issue_pkg::tag_t dec_tag,
    output dual_issue_pkg::op_t  dec_op,
    output dual_issue_pkg::data_t dec_data
);

    dual_issue_pkg::pld_t pld_q;

    // empty, or the held item leaves this cycle
    assign in_rdy = !dec_vld || dec_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_vld <= 1'b0;
        end else if (in_rdy) begin
            dec_vld <= in_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld && in_rdy) begin
            pld_q <= in_pld;
        end
    end

    // split payload into its fields
    assign dec_tag  = pld_q[`DI_TAG_LSB +: `DI_TAG_W];
    assign dec_op   = pld_q[`DI_OP_LSB +: `DI_OP_W];
    assign dec_data = pld_q[`DI_DATA_W-1:0];

endmodule

/* op_execute.sv */
`timescale 1ns/10ps
`include "dual_issue_defs.svh"

module op_execute (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  dec_vld,
    output logic                  dec_rdy,
    input  dual_issue_pkg::tag_t  dec_tag,
    input  dual_issue_pkg::op_t   dec_op,
    input  dual_issue_pkg::data_t dec_data,

    output logic                  exe_vld,
    input  logic                  exe_rdy,
    output dual_issue_pkg::tag_t  exe_tag,
    output dual_issue_pkg::data_t exe_data
);

    dual_issue_pkg::data_t rev_data;
    dual_issue_pkg::data_t pop_cnt;
    dual_issue_pkg::data_t result;

    always_comb begin
        rev_data = '0;
        pop_cnt  = '0;
        for (int i = 0; i < `DI_DATA_W; i++) begin
            rev_data[i] = dec_data[`DI_DATA_W-1-i];
            pop_cnt     = pop_cnt + dual_issue_pkg::data_t'(dec_data[i]);
        end
    end

    always_comb begin
        case (dec_op)
            2'd0:    result = dec_data;
            2'd1:    result = dual_issue_pkg::data_t'(dec_data + 1'b1); // wraps at 256
            2'd2:    result = rev_data;
            default: result = pop_cnt;
        endcase
    end

    assign dec_rdy = !exe_vld || exe_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_vld <= 1'b0;
        end else if (dec_rdy) begin
            exe_vld <= dec_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_vld && dec_rdy) begin
            exe_tag  <= dec_tag;
            exe_data <= result;
        end
    end

endmodule

/* result_merge.sv */
`timescale 1ns/10ps

module result_merge (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  lane0_vld,
    input  dual_issue_pkg::tag_t  lane0_tag,
    input  dual_issue_pkg::data_t lane0_data,
    output logic                  lane0_rdy,

    input  logic                  lane1_vld,
    input  dual_issue_pkg::tag_t  lane1_tag,
    input  dual_issue_pkg::data_t lane1_data,
    output logic                  lane1_rdy,

    output logic                  res_vld,
    input  logic                  res_rdy,
    output dual_issue_pkg::tag_t  res_tag,
    output dual_issue_pkg::data_t res_data
);

    logic rr_ptr;   // lane favoured on a tie
    logic out_free;
    logic sel1;     // take lane 1 this cycle
    logic take;

    assign out_free = !res_vld || res_rdy;

    // lane 1 wins if alone, or on a tie when the pointer favours it
    assign sel1 = lane1_vld && (!lane0_vld || rr_ptr);
    assign take = out_free && (lane0_vld || lane1_vld);

    assign lane0_rdy = out_free && !sel1;
    assign lane1_rdy = out_free && sel1;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_vld <= 1'b0;
            rr_ptr  <= 1'b0;
        end else begin
            if (out_free) begin
                res_vld <= lane0_vld || lane1_vld;
            end
            if (take) begin
                rr_ptr <= !sel1; // favour the other lane next
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_tag  <= sel1 ? lane1_tag : lane0_tag;
            res_data <= sel1 ? lane1_data : lane0_data;
        end
    end

endmodule

/* dual_issue_top.sv */
`timescale 1ns/10ps
`include "dual_issue_defs.svh"

module dual_issue_top (
    input  logic                      clk,
    input  logic                      reset,

    input  dual_issue_pkg::req_mask_t req_vld,
    output dual_issue_pkg::req_mask_t req_rdy,
    input  dual_issue_pkg::pld_t      req_pld [`DI_N_REQ-1:0],

    output logic                      res_vld,
    input  logic                      res_rdy,
    output dual_issue_pkg::tag_t      res_tag,
    output dual_issue_pkg::data_t     res_data
);

    logic [1:0]            grant_vld;
    logic [1:0]            grant_rdy;
    dual_issue_pkg::pld_t  grant_pld [1:0];

    logic [1:0]            dec_vld;
    logic [1:0]            dec_rdy;
    dual_issue_pkg::tag_t  dec_tag [1:0];
    dual_issue_pkg::op_t   dec_op [1:0];
    dual_issue_pkg::data_t dec_data [1:0];

    logic [1:0]            exe_vld;
    logic [1:0]            exe_rdy;
    dual_issue_pkg::tag_t  exe_tag [1:0];
    dual_issue_pkg::data_t exe_data [1:0];

    n_to_2_arb #(
        .N        (`DI_N_REQ),
        .PLD_WIDTH(`DI_PLD_W)
    ) u_arb (
        .clk      (clk),
        .reset    (reset),
        .req_vld  (req_vld),
        .req_rdy  (req_rdy),
        .req_pld  (req_pld),
        .grant_vld(grant_vld),
        .grant_rdy(grant_rdy),
        .grant_pld(grant_pld)
    );

    // two identical issue lanes
    for (genvar l = 0; l < 2; l++) begin : g_lane
        op_decode u_dec (
            .clk     (clk),
            .reset   (reset),
            .in_vld  (grant_vld[l]),
            .in_rdy  (grant_rdy[l]),
            .in_pld  (grant_pld[l]),
            .dec_vld (dec_vld[l]),
            .dec_rdy (dec_rdy[l]),
            .dec_tag (dec_tag[l]),
            .dec_op  (dec_op[l]),
            .dec_data(dec_data[l])
        );

        op_execute u_exe (
            .clk     (clk),
            .reset   (reset),
            .dec_vld (dec_vld[l]),
            .dec_rdy (dec_rdy[l]),
            .dec_tag (dec_tag[l]),
            .dec_op  (dec_op[l]),
            .dec_data(dec_data[l]),
            .exe_vld (exe_vld[l]),
            .exe_rdy (exe_rdy[l]),
            .exe_tag (exe_tag[l]),
            .exe_data(exe_data[l])
        );
    end

    result_merge u_merge (
        .clk       (clk),
        .reset     (reset),
        .lane0_vld (exe_vld[0]),
        .lane0_tag (exe_tag[0]),
        .lane0_data(exe_data[0]),
        .lane0_rdy (exe_rdy[0]),
        .lane1_vld (exe_vld[1]),
        .lane1_tag (exe_tag[1]),
        .lane1_data(exe_data[1]),
        .lane1_rdy (exe_rdy[1]),
        .res_vld   (res_vld),
        .res_rdy   (res_rdy),
        .res_tag   (res_tag),
        .res_data  (res_data)
    );

endmodule

/* dual_issue_tb.sv */
`timescale 1ns/10ps
`include "dual_issue_defs.svh"

module dual_issue_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int N_OPS        = 400;
    localparam int WATCHDOG_NS  = N_OPS * 20 * CLK_PERIOD;
    localparam int N_TAGS       = 1 << `DI_TAG_W;
    localparam int DRAIN_CYCLES = 50;

    logic                      clk;
    logic                      reset;
    dual_issue_pkg::req_mask_t req_vld;
    dual_issue_pkg::req_mask_t req_rdy;
    dual_issue_pkg::pld_t      req_pld [`DI_N_REQ-1:0];
    logic                      res_vld;
    logic                      res_rdy;
    dual_issue_pkg::tag_t      res_tag;
    dual_issue_pkg::data_t     res_data;

    // reference model keyed by tag
    logic [N_TAGS-1:0]         outstanding;
    dual_issue_pkg::data_t     exp_data [0:N_TAGS-1];
    dual_issue_pkg::req_mask_t busy;  // op issued and its result not back yet
    int                        issued;
    int                        returned;

    logic                      reset_q = 1'b0;
    dual_issue_pkg::tag_t      res_tag_q;
    dual_issue_pkg::data_t     res_data_q;
    logic                      res_known;
    dual_issue_pkg::data_t     exp_res;

    dual_issue_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .req_vld (req_vld),
        .req_rdy (req_rdy),
        .req_pld (req_pld),
        .res_vld (res_vld),
        .res_rdy (res_rdy),
        .res_tag (res_tag),
        .res_data(res_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        reset_q    <= reset;
        res_tag_q  <= res_tag;
        res_data_q <= res_data;
    end

    assign res_known = outstanding[res_tag];
    assign exp_res   = exp_data[res_tag];

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic value_mismatch(string name, int expected, int actual);
        $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        abort_run();
    endtask

    task automatic report_error(string msg);
        $display("Error: %s", msg);
        abort_run();
    endtask

    function automatic dual_issue_pkg::data_t expected_result(dual_issue_pkg::op_t op,
                                                              dual_issue_pkg::data_t d);
        dual_issue_pkg::data_t r;
        r = '0;
        case (op)
            2'd0: r = d;
            2'd1: r = dual_issue_pkg::data_t'((int'(d) + 1) % 256);
            2'd2: begin
                for (int i = 0; i < `DI_DATA_W; i++) begin
                    r[`DI_DATA_W-1-i] = d[i];
                end
            end
            default: begin
                for (int i = 0; i < `DI_DATA_W; i++) begin
                    r = r + d[i]; // count ones
                end
            end
        endcase
        return r;
    endfunction

    // a waiting request below some granted bit
    function automatic bit low_request_skipped(dual_issue_pkg::req_mask_t vld,
                                               dual_issue_pkg::req_mask_t rdy);
        bit granted_above;
        granted_above = 1'b0;
        for (int i = `DI_N_REQ-1; i >= 0; i--) begin
            if (vld[i] && !rdy[i] && granted_above) begin
                return 1'b1;
            end
            if (rdy[i]) begin
                granted_above = 1'b1;
            end
        end
        return 1'b0;
    endfunction

    a_reset: assert property (@(posedge clk) reset_q |-> !res_vld)
        else value_mismatch("reset_res_vld", 0, $sampled(res_vld));

    a_res_known: assert property (@(posedge clk) disable iff (reset)
        res_vld && res_rdy |-> res_known)
        else report_error("result returned for a tag with no outstanding operation");

    a_res_data: assert property (@(posedge clk) disable iff (reset)
        res_vld && res_rdy && res_known |-> res_data == exp_res)
        else value_mismatch("result_data", $sampled(exp_res), $sampled(res_data));

    a_rdy_subset: assert property (@(posedge clk) disable iff (reset)
        (req_rdy & ~req_vld) == '0)
        else value_mismatch("req_rdy_subset", $sampled(req_rdy & req_vld), $sampled(req_rdy));

    a_two_grants: assert property (@(posedge clk) disable iff (reset)
        $countones(req_rdy) <= 2)
        else report_error("more than two requests granted in one cycle");

    a_priority: assert property (@(posedge clk) disable iff (reset)
        $countones(req_rdy) < 2 |-> !low_request_skipped(req_vld, req_rdy))
        else report_error("a lower request was skipped while a grant was still free");

    a_hold_vld: assert property (@(posedge clk) disable iff (reset)
        res_vld && !res_rdy |=> res_vld)
        else report_error("res_vld dropped while the output was stalled");

    a_hold_tag: assert property (@(posedge clk) disable iff (reset)
        res_vld && !res_rdy |=> res_tag == res_tag_q)
        else value_mismatch("hold_tag", $sampled(res_tag_q), $sampled(res_tag));

    a_hold_data: assert property (@(posedge clk) disable iff (reset)
        res_vld && !res_rdy |=> res_data == res_data_q)
        else value_mismatch("hold_data", $sampled(res_data_q), $sampled(res_data));

    initial begin
        #(WATCHDOG_NS);
        report_error("watchdog timed out before all operations were issued and drained");
    end

    initial begin
        dual_issue_pkg::op_t       op;
        dual_issue_pkg::data_t     operand;
        dual_issue_pkg::req_mask_t acc;
        logic                      took;
        dual_issue_pkg::tag_t      took_tag;
        int                        stall;
        int                        drain;

        void'($urandom(32'h1e14));
        clk         = 1'b0;
        reset       = 1'b1;
        req_vld     = '0;
        res_rdy     = 1'b0;
        outstanding = '0;
        busy        = '0;
        issued      = 0;
        returned    = 0;
        stall       = 0;
        drain       = DRAIN_CYCLES;
        for (int i = 0; i < `DI_N_REQ; i++) begin
            req_pld[i] = '0;
        end
        for (int i = 0; i < N_TAGS; i++) begin
            exp_data[i] = '0;
        end

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        while (drain > 0) begin
            @(negedge clk); // handshakes of the coming edge
            acc      = req_vld & req_rdy;
            took     = res_vld && res_rdy;
            took_tag = res_tag;
            @(posedge clk);
            #1;
            if (took) begin
                outstanding[took_tag] = 1'b0;
                busy[took_tag]        = 1'b0;
                returned++;
            end
            for (int i = 0; i < `DI_N_REQ; i++) begin
                if (acc[i]) begin
                    outstanding[i] = 1'b1;
                    req_vld[i]     = 1'b0;
                end
            end
            for (int i = 0; i < `DI_N_REQ; i++) begin
                if (!busy[i] && issued < N_OPS && ($urandom % 3 == 0)) begin
                    // first four ops cover every opcode
                    op = (issued < 4) ? dual_issue_pkg::op_t'(issued)
                                      : dual_issue_pkg::op_t'($urandom % 4);
                    operand     = dual_issue_pkg::data_t'($urandom);
                    req_pld[i]  = {dual_issue_pkg::tag_t'(i), op, operand};
                    exp_data[i] = expected_result(op, operand);
                    req_vld[i]  = 1'b1;
                    busy[i]     = 1'b1;
                    issued++;
                end
            end
            if (issued == N_OPS) begin
                res_rdy = 1'b1; // drain
                drain--;
            end else if (stall > 0) begin
                res_rdy = 1'b0;
                stall--;
            end else if ($urandom % 20 == 0) begin
                stall   = 8 + $urandom % 12; // long stall
                res_rdy = 1'b0;
            end else begin
                res_rdy = ($urandom % 3 != 0);
            end
        end

        if (outstanding != '0) begin
            value_mismatch("outstanding_at_end", 0, outstanding);
        end else if (returned != issued) begin
            value_mismatch("returned_count", issued, returned);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* dual_issue_top.f */
+incdir+.
dual_issue_pkg.sv
cmn_lead_one.sv
n_to_2_arb.sv
op_decode.sv
op_execute.sv
result_merge.sv
dual_issue_top.sv
dual_issue_tb.sv

/* Bender.yml */
package:
  name: dual_issue

sources:
  - include_dirs:
      - .
    files:
      - dual_issue_pkg.sv
      - cmn_lead_one.sv
      - n_to_2_arb.sv
      - op_decode.sv
      - op_execute.sv
      - result_merge.sv
      - dual_issue_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dual_issue_tb.sv
